// File: design/vga_timing_cfg.svh
`ifndef VGA_TIMING_CFG_SVH
`define VGA_TIMING_CFG_SVH

// 640x480 at 60 Hz, 25.175 MHz nominal pixel rate

// Horizontal phase lengths, in pixels
`define H_DISPLAY 640
`define H_PULSE   96
`define H_BACK    48
`define H_FRONT   16

// Vertical phase lengths, in lines
`define V_DISPLAY 480
`define V_PULSE   2
`define V_BACK    33
`define V_FRONT   10

// Counter widths, wide enough for the longest phase
`define H_BITS 10
`define V_BITS 10

// Colour bar geometry
`define BAR_WIDTH 80  // Eight bars across the visible line

`endif

// File: design/vga_pkg.sv
`include "vga_timing_cfg.svh"

package vga_pkg;

    // Phase order follows the sync line itself. The pulse comes first so that
    // reset lands at the start of a line.
    typedef enum logic [1:0] {
        PH_PULSE   = 2'b00,  // Sync pulse
        PH_BACK    = 2'b01,  // Back porch
        PH_DISPLAY = 2'b10,  // Visible region
        PH_FRONT   = 2'b11   // Front porch
    } sync_phase_t;

    // Position inside the current phase
    typedef logic [`H_BITS-1:0] h_pos_t;
    typedef logic [`V_BITS-1:0] v_pos_t;

    // One bit per channel, enough for the eight bar colours
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    // Bar number, wraps after eight bars
    typedef logic [2:0] bar_index_t;

endpackage

// File: design/sync_fsm.sv
`timescale 1ns/1ns

// One axis of VGA timing. The same machine counts pixels in a line or lines
// in a frame, depending on its parameters and the enable it is given.
module sync_fsm #(
    parameter int PULSE   = 96,   // Sync pulse length
    parameter int BACK    = 48,   // Back porch length
    parameter int DISPLAY = 640,  // Visible length
    parameter int FRONT   = 16,   // Front porch length
    parameter int BITS    = 10    // Counter width
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    output vga_pkg::sync_phase_t phase,
    output logic [BITS-1:0]      position,
    output logic                 last
);
    import vga_pkg::*;

    sync_phase_t     state;
    sync_phase_t     next_state;
    logic [BITS-1:0] count;
    logic [BITS-1:0] phase_end;  // Final count of the current phase
    logic            at_end;

    // Length of the current phase and the phase that follows it
    always_comb begin
        unique case (state)
            PH_PULSE: begin
                phase_end  = BITS'(PULSE - 1);
                next_state = PH_BACK;
            end
            PH_BACK: begin
                phase_end  = BITS'(BACK - 1);
                next_state = PH_DISPLAY;
            end
            PH_DISPLAY: begin
                phase_end  = BITS'(DISPLAY - 1);
                next_state = PH_FRONT;
            end
            PH_FRONT: begin
                phase_end  = BITS'(FRONT - 1);
                next_state = PH_PULSE;
            end
            default: begin
                phase_end  = BITS'(PULSE - 1);
                next_state = PH_PULSE;
            end
        endcase
    end

    assign at_end = (count == phase_end);

    // Phase register and phase counter step together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= PH_PULSE;
            count <= '0;
        end else if (enable) begin
            if (at_end) begin
                state <= next_state;
                count <= '0;  // Each phase counts from zero
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign phase = state;

    // Position is only meaningful while visible
    assign position = (state == PH_DISPLAY) ? count : '0;

    // One enabled cycle at the very end of the period
    assign last = enable && (state == PH_FRONT) && at_end;

endmodule

// File: design/pattern_mixer.sv
`timescale 1ns/1ns
`include "vga_timing_cfg.svh"

// Turns the two axis phases into registered sync, data enable and a colour bar
// pattern that moves one bar to the left each frame.
module pattern_mixer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pix_en,
    input  logic                 hsync_active_high,
    input  logic                 vsync_active_high,
    input  vga_pkg::sync_phase_t h_phase,
    input  vga_pkg::sync_phase_t v_phase,
    input  vga_pkg::h_pos_t      h_pos,
    input  logic                 v_last,
    input  logic                 h_last,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de,
    output vga_pkg::rgb_t        rgb
);
    import vga_pkg::*;

    bar_index_t frame_cnt;   // Scroll offset, wraps after eight frames
    bar_index_t bar_index;
    logic       frame_end;
    logic       h_active;
    logic       v_active;
    logic       display;
    logic       hsync_next;
    logic       vsync_next;
    rgb_t       bar_colour;

    assign h_active = (h_phase == PH_PULSE);
    assign v_active = (v_phase == PH_PULSE);
    assign display  = (h_phase == PH_DISPLAY) && (v_phase == PH_DISPLAY);

    // Drive the active level only while in the pulse
    assign hsync_next = h_active ? hsync_active_high : ~hsync_active_high;
    assign vsync_next = v_active ? vsync_active_high : ~vsync_active_high;

    // Last pixel of the last line
    assign frame_end = pix_en & h_last & v_last;

    // Truncation to three bits gives the modulo-eight wrap
    assign bar_index = bar_index_t'(h_pos / `BAR_WIDTH) + frame_cnt;

    assign bar_colour.r = bar_index[2];
    assign bar_colour.g = bar_index[1];
    assign bar_colour.b = bar_index[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt <= '0;
        end else if (frame_end) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // Output stage, one enabled cycle behind the sync machines
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hsync <= ~hsync_active_high;  // Inactive level
            vsync <= ~vsync_active_high;
            de    <= 1'b0;
            rgb   <= '0;
        end else if (pix_en) begin
            hsync <= hsync_next;
            vsync <= vsync_next;
            de    <= display;
            rgb   <= display ? bar_colour : rgb_t'('0);  // Black outside the visible area
        end
    end

endmodule

// File: design/vga_timing_top.sv
`timescale 1ns/1ns
`include "vga_timing_cfg.svh"

// VGA timing and test pattern generator. pix_en lets a faster system clock
// drive the pixel rate; everything holds while it is low.
module vga_timing_top (
    input  logic          clk,
    input  logic          reset,
    input  logic          pix_en,
    input  logic          hsync_active_high,
    input  logic          vsync_active_high,
    output logic          hsync,
    output logic          vsync,
    output logic          de,
    output vga_pkg::rgb_t rgb
);
    import vga_pkg::*;

    sync_phase_t h_phase;
    sync_phase_t v_phase;
    h_pos_t      h_pos;
    logic        h_last;
    logic        v_last;
    logic        v_enable;  // One step per line

    assign v_enable = pix_en & h_last;

    sync_fsm #(
        .PULSE   (`H_PULSE),
        .BACK    (`H_BACK),
        .DISPLAY (`H_DISPLAY),
        .FRONT   (`H_FRONT),
        .BITS    (`H_BITS)
    ) h_sync (
        .clk      (clk),
        .reset    (reset),
        .enable   (pix_en),
        .phase    (h_phase),
        .position (h_pos),
        .last     (h_last)
    );

    // The pattern has no vertical variation, so the line number is not needed
    sync_fsm #(
        .PULSE   (`V_PULSE),
        .BACK    (`V_BACK),
        .DISPLAY (`V_DISPLAY),
        .FRONT   (`V_FRONT),
        .BITS    (`V_BITS)
    ) v_sync (
        .clk      (clk),
        .reset    (reset),
        .enable   (v_enable),
        .phase    (v_phase),
        .position (),
        .last     (v_last)
    );

    pattern_mixer mixer (
        .clk               (clk),
        .reset             (reset),
        .pix_en            (pix_en),
        .hsync_active_high (hsync_active_high),
        .vsync_active_high (vsync_active_high),
        .h_phase           (h_phase),
        .v_phase           (v_phase),
        .h_pos             (h_pos),
        .v_last            (v_last),
        .h_last            (h_last),
        .hsync             (hsync),
        .vsync             (vsync),
        .de                (de),
        .rgb               (rgb)
    );

endmodule

// File: tests/vga_tb.sv
`timescale 1ns/1ns
`include "vga_timing_cfg.svh"

module vga_tb;
    import vga_pkg::*;

    localparam int H_TOTAL = `H_PULSE + `H_BACK + `H_DISPLAY + `H_FRONT;  // 800 pixels
    localparam int V_TOTAL = `V_PULSE + `V_BACK + `V_DISPLAY + `V_FRONT;  // 525 lines
    localparam int H_START = `H_PULSE + `H_BACK;  // First visible pixel
    localparam int V_START = `V_PULSE + `V_BACK;  // First visible line
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // Two full frames plus one gated frame at two-thirds duty is about 1.47M cycles
    localparam int TIMEOUT_CYCLES = 2_000_000;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        rgb_t rgb;
    } expect_t;

    logic clk = 1'b0;
    logic reset;
    logic pix_en;
    logic hsync_active_high;
    logic vsync_active_high;
    logic hsync;
    logic vsync;
    logic de;
    rgb_t rgb;

    // Model state, stepped only on enabled edges
    int          h_cnt = 0;
    int          v_cnt = 0;
    int          frame_cnt = 0;
    expect_t     model_out;
    logic        fresh = 1'b0;  // Set when the last edge updated the outputs
    logic        hpol_used = 1'b0;
    logic        vpol_used = 1'b0;
    int          de_count = 0;
    int          hs_count = 0;
    int          vs_count = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'ha429;

    vga_timing_top DUT (
        .clk               (clk),
        .reset             (reset),
        .pix_en            (pix_en),
        .hsync_active_high (hsync_active_high),
        .vsync_active_high (vsync_active_high),
        .hsync             (hsync),
        .vsync             (vsync),
        .de                (de),
        .rgb               (rgb)
    );

    always #5 clk = ~clk;

    // Expected outputs for one pixel, counted from the start of the sync pulse
    function automatic expect_t expected_outputs(input int h, input int v, input int frame,
                                                 input logic hpol, input logic vpol);
        expect_t e;
        int      bar;
        logic    visible;
        visible = (h >= H_START) && (h < H_START + `H_DISPLAY) &&
                  (v >= V_START) && (v < V_START + `V_DISPLAY);
        e.hsync = (h < `H_PULSE) ? hpol : ~hpol;
        e.vsync = (v < `V_PULSE) ? vpol : ~vpol;
        e.de    = visible;
        e.rgb   = '0;
        if (visible) begin
            bar     = ((h - H_START) / `BAR_WIDTH + frame) % 8;  // Bars scroll per frame
            e.rgb.r = bar[2];
            e.rgb.g = bar[1];
            e.rgb.b = bar[0];
        end
        return e;
    endfunction

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_random_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // Two bits per try, retry on 11, so the enable is high two times in three
    task automatic random_enable(output logic en);
        logic b1;
        logic b0;
        do begin
            take_random_bit(b1);
            take_random_bit(b0);
        end while (b1 && b0);
        en = ~b1;
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, want, got);
            $display("*** TEST FAILED ***");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t want);
        if (got !== want) begin
            $display("[FAIL] %0t ns: rgb expected %b, got %b (h %0d, v %0d)",
                     $time, want, got, h_cnt, v_cnt);
            $display("*** TEST FAILED ***");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            $display("[FAIL] %0t ns: %s count per frame expected %0d, got %0d",
                     $time, name, want, got);
            $display("*** TEST FAILED ***");
            $fatal(1, "Count mismatch");
        end
    endtask

    // Whole-frame totals from the timing numbers
    task automatic check_frame_totals();
        check_count("de", de_count, `H_DISPLAY * `V_DISPLAY);
        check_count("hsync", hs_count, `H_PULSE * V_TOTAL);
        check_count("vsync", vs_count, `V_PULSE * H_TOTAL);
        de_count = 0;
        hs_count = 0;
        vs_count = 0;
    endtask

    // Runs one frame worth of enabled cycles, then idles two cycles
    task automatic drive_frame(input bit gated);
        int   driven;
        logic en;
        driven = 0;
        while (driven < FRAME_CYCLES) begin
            @(posedge clk);
            if (gated) begin
                random_enable(en);
            end else begin
                en = 1'b1;
            end
            pix_en <= en;
            if (en) begin
                driven++;
            end
        end
        @(posedge clk);
        pix_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // Reference model, sees the inputs the DUT samples on the same edge
    always @(posedge clk) begin
        if (!reset && pix_en) begin
            model_out = expected_outputs(h_cnt, v_cnt, frame_cnt,
                                         hsync_active_high, vsync_active_high);
            hpol_used = hsync_active_high;
            vpol_used = vsync_active_high;
            fresh     = 1'b1;
            h_cnt     = h_cnt + 1;
            if (h_cnt == H_TOTAL) begin
                h_cnt = 0;
                v_cnt = v_cnt + 1;
                if (v_cnt == V_TOTAL) begin
                    v_cnt     = 0;
                    frame_cnt = (frame_cnt + 1) % 8;
                end
            end
        end else begin
            fresh = 1'b0;
        end
    end

    // Compare on the falling edge, away from the update
    always @(negedge clk) begin
        check_bit("hsync", hsync, model_out.hsync);
        check_bit("vsync", vsync, model_out.vsync);
        check_bit("de", de, model_out.de);
        check_rgb(rgb, model_out.rgb);
        if (fresh) begin
            de_count = de_count + int'(de);
            hs_count = hs_count + int'(hsync == hpol_used);
            vs_count = vs_count + int'(vsync == vpol_used);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycle_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        reset             = 1'b1;
        pix_en            = 1'b0;
        hsync_active_high = 1'b0;  // Standard 640x480 uses negative syncs
        vsync_active_high = 1'b0;
        model_out.hsync   = 1'b1;  // Inactive levels after reset
        model_out.vsync   = 1'b1;
        model_out.de      = 1'b0;
        model_out.rgb     = '0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);  // Outputs must stay at reset values

        drive_frame(1'b0);
        check_frame_totals();

        // Second frame with both syncs flipped, bars one step further on
        hsync_active_high <= 1'b1;
        vsync_active_high <= 1'b1;
        @(posedge clk);
        drive_frame(1'b0);
        check_frame_totals();

        // Mixed polarity and a gated pixel enable
        hsync_active_high <= 1'b0;
        @(posedge clk);
        drive_frame(1'b1);
        check_frame_totals();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/vga_pkg.sv
design/sync_fsm.sv
design/pattern_mixer.sv
design/vga_timing_top.sv
tests/vga_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the VGA timing testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -Wno-fatal --timescale 1ns/1ns \
    --top-module vga_tb -f project.f -o vga_sim \
    && ./obj_dir/vga_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
